// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f rv_pipe.f --top-module rv_pipe_tb \
		-Mdir obj_dir -o rv_pipe_tb

run: compile
	./obj_dir/rv_pipe_tb | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: logic/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
  input  logic                   clk,
  input  logic                   rst,
  input  rv_pipe_pkg::fd_t       fd,
  input  rv_pipe_pkg::redirect_t redirect,
  input  rv_pipe_pkg::wb_t       wb,
  output logic                   stall,
  output rv_pipe_pkg::dx_t       dx
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  opcode_t   opcode;
  reg_addr_t rs1;
  reg_addr_t rs2;
  word_t     rs1_data;
  word_t     rs2_data;
  logic      uses_rs1;
  logic      uses_rs2;
  reg_addr_t dx_rd;
  logic      dx_is_load;

  function automatic dx_t dx_bubble(cycle_status_e s);
    return '{pc: '0, insn: insn_nop, rs1_data: '0, rs2_data: '0, status: s};
  endfunction

  assign opcode = fd.insn[6:0];
  assign rs1    = fd.insn[19:15];
  assign rs2    = fd.insn[24:20];

  reg_file reg_file_i (
    .clk      (clk),
    .rst      (rst),
    .wb       (wb),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // only real source operands may cause a stall
  assign uses_rs1 = opcode inside {op_reg_imm, op_reg_reg, op_branch, op_load, op_store, op_jalr};
  assign uses_rs2 = opcode inside {op_reg_reg, op_branch, op_store};

  // load in execute feeding this instruction
  assign dx_rd      = dx.insn[11:7];
  assign dx_is_load = dx.insn[6:0] == op_load;
  assign stall = dx_is_load && dx_rd != '0 &&
                 ((uses_rs1 && rs1 == dx_rd) || (uses_rs2 && rs2 == dx_rd));

  always_ff @(posedge clk) begin
    if (rst) begin
      dx <= dx_bubble(cycle_reset);
    end else if (redirect.taken) begin
      dx <= dx_bubble(cycle_taken_branch);
    end else if (stall) begin
      dx <= dx_bubble(cycle_load2use);
    end else begin
      dx <= '{pc: fd.pc, insn: fd.insn, rs1_data: rs1_data, rs2_data: rs2_data,
              status: fd.status};
    end
  end

  // a load and a jump cannot both sit in execute
  stall_vs_redirect: assert property (@(posedge clk) disable iff (rst)
    !(stall && redirect.taken));

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/10ps

module execute_stage (
  input  logic                    clk,
  input  logic                    rst,
  input  rv_pipe_pkg::dx_t        dx,
  input  rv_pipe_pkg::wb_t        wb,
  output rv_pipe_pkg::redirect_t  redirect,
  output rv_pipe_pkg::xm_t        xm
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic       alt;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  reg_addr_t  xm_rd;
  logic       mx_ok;
  word_t      op_a;
  word_t      op_b_reg;
  word_t      op_b;
  logic [4:0] shamt;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  word_t      alu;
  logic       branch_cond;
  word_t      result;
  logic       take;
  word_t      target;

  // mx first, then wx, then the value read in decode
  function automatic word_t forward(reg_addr_t rs, word_t from_dx, logic mx_valid,
                                    reg_addr_t mx_rd, word_t mx_data, wb_t w);
    if (mx_valid && mx_rd == rs) begin
      return mx_data;
    end else if (w.we && w.rd == rs) begin
      return w.data;
    end
    return from_dx;
  endfunction

  assign opcode = dx.insn[6:0];
  assign funct3 = dx.insn[14:12];
  assign alt    = dx.insn[31:25] == funct7_alt;
  assign rs1    = dx.insn[19:15];
  assign rs2    = dx.insn[24:20];

  // a load in memory only has its address here, so it never feeds mx
  assign xm_rd = xm.insn[11:7];
  assign mx_ok = writes_rd(xm.insn[6:0]) && xm.insn[6:0] != op_load && xm_rd != '0;

  assign op_a     = forward(rs1, dx.rs1_data, mx_ok, xm_rd, xm.result, wb);
  assign op_b_reg = forward(rs2, dx.rs2_data, mx_ok, xm_rd, xm.result, wb);

  assign imm_i = {{20{dx.insn[31]}}, dx.insn[31:20]};
  assign imm_s = {{20{dx.insn[31]}}, dx.insn[31:25], dx.insn[11:7]};
  assign imm_b = {{20{dx.insn[31]}}, dx.insn[7], dx.insn[30:25], dx.insn[11:8], 1'b0};
  assign imm_u = {dx.insn[31:12], 12'd0};
  assign imm_j = {{12{dx.insn[31]}}, dx.insn[19:12], dx.insn[20], dx.insn[30:21], 1'b0};

  assign op_b  = (opcode == op_reg_reg) ? op_b_reg : imm_i;
  assign shamt = op_b[4:0];

  always_comb begin
    case (funct3)
      3'b000: alu = (opcode == op_reg_reg && alt) ? op_a - op_b : op_a + op_b;
      3'b001: alu = op_a << shamt;
      3'b010: alu = {31'd0, $signed(op_a) < $signed(op_b)};
      3'b011: alu = {31'd0, op_a < op_b};
      3'b100: alu = op_a ^ op_b;
      3'b101: alu = alt ? word_t'($signed(op_a) >>> shamt) : op_a >> shamt;
      3'b110: alu = op_a | op_b;
      default: alu = op_a & op_b;
    endcase
  end

  // branches always compare the two registers
  always_comb begin
    case (funct3)
      3'b000: branch_cond = op_a == op_b_reg;
      3'b001: branch_cond = op_a != op_b_reg;
      3'b100: branch_cond = $signed(op_a) < $signed(op_b_reg);
      3'b101: branch_cond = $signed(op_a) >= $signed(op_b_reg);
      3'b110: branch_cond = op_a < op_b_reg;
      3'b111: branch_cond = op_a >= op_b_reg;
      default: branch_cond = 1'b0;
    endcase
  end

  always_comb begin
    result = alu;
    take   = 1'b0;
    target = dx.pc + imm_b;
    case (opcode)
      op_lui:    result = imm_u;
      op_auipc:  result = dx.pc + imm_u;
      op_jal: begin
        result = dx.pc + 32'd4;
        take   = 1'b1;
        target = dx.pc + imm_j;
      end
      op_jalr: begin
        result = dx.pc + 32'd4;
        take   = 1'b1;
        target = (op_a + imm_i) & ~32'd1;
      end
      op_branch: take   = branch_cond;
      op_load:   result = op_a + imm_i;
      op_store:  result = op_a + imm_s;
      default: begin
      end
    endcase
  end

  assign redirect = '{taken: take, target: target};

  always_ff @(posedge clk) begin
    if (rst) begin
      xm <= '{pc: '0, insn: insn_nop, result: '0, store_data: '0, status: cycle_reset};
    end else begin
      xm <= '{pc: dx.pc, insn: dx.insn, result: result, store_data: op_b_reg,
              status: dx.status};
    end
  end

endmodule

// File: logic/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   stall,
  input  rv_pipe_pkg::redirect_t redirect,
  input  rv_isa_pkg::word_t      imem_data,
  output rv_isa_pkg::word_t      imem_addr,
  output rv_pipe_pkg::fd_t       fd
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  word_t pc;

  assign imem_addr = pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
      fd <= '{pc: '0, insn: insn_nop, status: cycle_reset};
    end else if (redirect.taken) begin
      // the word fetched this cycle is on the wrong path
      pc <= redirect.target;
      fd <= '{pc: '0, insn: insn_nop, status: cycle_taken_branch};
    end else if (!stall) begin
      pc <= pc + 32'd4;
      fd <= '{pc: pc, insn: imem_data, status: cycle_no_stall};
    end
  end

  // targets from execute must keep the pc on a word boundary
  pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

// File: logic/reg_file.sv
`timescale 1ns/10ps

module reg_file (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_pipe_pkg::wb_t      wb,
  input  rv_isa_pkg::reg_addr_t rs1,
  input  rv_isa_pkg::reg_addr_t rs2,
  output rv_isa_pkg::word_t     rs1_data,
  output rv_isa_pkg::word_t     rs2_data
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  // x1..x31, x0 has no storage
  word_t regs [1:31];

  // x0 reads zero, a same-cycle write is seen by the reader
  function automatic word_t read_port(reg_addr_t a, word_t stored, wb_t w);
    if (a == '0) begin
      return '0;
    end else if (w.we && w.rd == a) begin
      return w.data;
    end
    return stored;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.we) begin
      regs[wb.rd] <= wb.data;
    end
  end

  assign rs1_data = read_port(rs1, regs[rs1], wb);
  assign rs2_data = read_port(rs2, regs[rs2], wb);

  // writeback must already have dropped writes to x0
  no_x0_write: assert property (@(posedge clk) disable iff (rst) wb.we |-> wb.rd != '0);

endmodule

// File: logic/result_stage.sv
`timescale 1ns/10ps

module result_stage (
  input  logic                clk,
  input  logic                rst,
  input  rv_pipe_pkg::xm_t    xm,
  input  rv_isa_pkg::word_t   dmem_rdata,
  output rv_isa_pkg::word_t   dmem_addr,
  output rv_isa_pkg::word_t   dmem_wdata,
  output logic [3:0]          dmem_we,
  output rv_pipe_pkg::wb_t    wb,
  output logic                halt,
  output rv_pipe_pkg::trace_t trace
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  opcode_t   opcode;
  reg_addr_t rd;
  reg_addr_t rs2;
  logic      wm_hit;
  logic      rd_we;
  word_t     rd_data;

  assign opcode = xm.insn[6:0];
  assign rd     = xm.insn[11:7];
  assign rs2    = xm.insn[24:20];

  // store data from the instruction now in writeback
  assign wm_hit = wb.we && wb.rd == rs2;

  assign dmem_addr  = xm.result;
  assign dmem_wdata = wm_hit ? wb.data : xm.store_data;
  // word stores only
  assign dmem_we    = (opcode == op_store) ? 4'b1111 : 4'b0000;

  assign rd_we   = writes_rd(opcode) && rd != '0;
  assign rd_data = (opcode == op_load) ? dmem_rdata : xm.result;

  always_ff @(posedge clk) begin
    if (rst) begin
      wb    <= '{we: 1'b0, rd: '0, data: '0};
      trace <= '{pc: '0, insn: insn_nop, status: cycle_reset};
    end else begin
      wb    <= '{we: rd_we, rd: rd, data: rd_data};
      trace <= '{pc: xm.pc, insn: xm.insn, status: xm.status};
    end
  end

  assign halt = trace.insn == insn_ecall;

  // store address comes from execute, must be word aligned
  store_aligned: assert property (@(posedge clk) disable iff (rst)
    dmem_we != 4'b0000 |-> dmem_addr[1:0] == 2'b00);

endmodule

// File: logic/rv_isa_pkg.sv
package rv_isa_pkg;

  // data and address width
  localparam int xlen = 32;
  // register index width
  localparam int reg_addr_w = 5;

  typedef logic [xlen-1:0] word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;
  typedef logic [6:0] opcode_t;

  // base opcodes, rv32i
  localparam opcode_t op_load    = 7'b00_000_11;
  localparam opcode_t op_store   = 7'b01_000_11;
  localparam opcode_t op_branch  = 7'b11_000_11;
  localparam opcode_t op_jalr    = 7'b11_001_11;
  localparam opcode_t op_jal     = 7'b11_011_11;
  localparam opcode_t op_reg_imm = 7'b00_100_11;
  localparam opcode_t op_reg_reg = 7'b01_100_11;
  localparam opcode_t op_auipc   = 7'b00_101_11;
  localparam opcode_t op_lui     = 7'b01_101_11;
  localparam opcode_t op_system  = 7'b11_100_11;

  // sub and sra/srai marker in funct7
  localparam logic [6:0] funct7_alt = 7'b010_0000;

  // ecall has every field zero except the opcode
  localparam word_t insn_ecall = {25'd0, op_system};

  // bubble slot
  localparam word_t insn_nop = '0;

  // opcodes that produce a value for rd
  function automatic logic writes_rd(opcode_t op);
    return op inside {op_lui, op_auipc, op_reg_imm, op_reg_reg, op_jal, op_jalr, op_load};
  endfunction

endpackage

// File: logic/rv_pipe.sv
`timescale 1ns/10ps

module rv_pipe (
  input  logic                clk,
  input  logic                rst,
  input  rv_isa_pkg::word_t   imem_data,
  input  rv_isa_pkg::word_t   dmem_rdata,
  output rv_isa_pkg::word_t   imem_addr,
  output rv_isa_pkg::word_t   dmem_addr,
  output rv_isa_pkg::word_t   dmem_wdata,
  output logic [3:0]          dmem_we,
  output logic                halt,
  output rv_pipe_pkg::trace_t trace
);
  import rv_pipe_pkg::*;

  fd_t       fd;
  dx_t       dx;
  xm_t       xm;
  wb_t       wb;
  redirect_t redirect;
  logic      stall;

  fetch_unit fetch_unit_i (
    .clk       (clk),
    .rst       (rst),
    .stall     (stall),
    .redirect  (redirect),
    .imem_data (imem_data),
    .imem_addr (imem_addr),
    .fd        (fd)
  );

  decode_stage decode_stage_i (
    .clk      (clk),
    .rst      (rst),
    .fd       (fd),
    .redirect (redirect),
    .wb       (wb),
    .stall    (stall),
    .dx       (dx)
  );

  execute_stage execute_stage_i (
    .clk      (clk),
    .rst      (rst),
    .dx       (dx),
    .wb       (wb),
    .redirect (redirect),
    .xm       (xm)
  );

  // memory access and writeback
  result_stage result_stage_i (
    .clk        (clk),
    .rst        (rst),
    .xm         (xm),
    .dmem_rdata (dmem_rdata),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .wb         (wb),
    .halt       (halt),
    .trace      (trace)
  );

endmodule

// File: logic/rv_pipe_pkg.sv
package rv_pipe_pkg;

  import rv_isa_pkg::*;

  // what occupies writeback in a given cycle, one-hot
  typedef enum logic [3:0] {
    cycle_reset        = 4'd1,
    cycle_no_stall     = 4'd2,
    cycle_taken_branch = 4'd4,
    cycle_load2use     = 4'd8
  } cycle_status_e;

  typedef struct packed {
    word_t         pc;
    word_t         insn;
    cycle_status_e status;
  } fd_t;

  typedef struct packed {
    word_t         pc;
    word_t         insn;
    word_t         rs1_data;
    word_t         rs2_data;
    cycle_status_e status;
  } dx_t;

  typedef struct packed {
    word_t         pc;
    word_t         insn;
    // alu result, link address or memory address
    word_t         result;
    word_t         store_data;
    cycle_status_e status;
  } xm_t;

  // register write port, also the source for wd, wx and wm bypass
  typedef struct packed {
    logic      we;
    reg_addr_t rd;
    word_t     data;
  } wb_t;

  typedef struct packed {
    logic  taken;
    word_t target;
  } redirect_t;

  typedef struct packed {
    word_t         pc;
    word_t         insn;
    cycle_status_e status;
  } trace_t;

endpackage

// File: rv_pipe.f
logic/rv_isa_pkg.sv
logic/rv_pipe_pkg.sv
logic/reg_file.sv
logic/fetch_unit.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/rv_pipe.sv
testbench/rv_pipe_mem.sv
testbench/rv_pipe_tb.sv

// File: testbench/rv_pipe_mem.sv
`timescale 1ns/10ps

module rv_pipe_mem (
  input  logic                clk,
  input  rv_isa_pkg::word_t   imem_addr,
  output rv_isa_pkg::word_t   imem_data,
  input  rv_isa_pkg::word_t   dmem_addr,
  input  rv_isa_pkg::word_t   dmem_wdata,
  input  logic [3:0]          dmem_we,
  output rv_isa_pkg::word_t   dmem_rdata
);
  import rv_isa_pkg::*;

  localparam int prog_len = 21;

  word_t       imem [0:63];
  word_t       dmem [0:255];
  logic [15:0] lfsr;

  // fibonacci lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_imm(output logic [11:0] v);
    for (int i = 0; i < 12; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[10:0], lfsr[0]};
    end
  endtask

  function automatic word_t enc_i(logic [11:0] imm, int rs1, logic [2:0] f3, int rd,
                                  opcode_t op);
    return {imm, rs1[4:0], f3, rd[4:0], op};
  endfunction

  function automatic word_t enc_r(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op_reg_reg};
  endfunction

  function automatic word_t enc_s(logic [11:0] imm, int rs2);
    return {imm[11:5], rs2[4:0], 5'd0, 3'b010, imm[4:0], op_store};
  endfunction

  function automatic word_t enc_b(logic [12:0] imm, int rs2, int rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], op_branch};
  endfunction

  initial begin
    logic [11:0] r0;
    logic [11:0] r1;
    logic [11:0] r2;
    lfsr = 16'd53546;
    draw_imm(r0);
    draw_imm(r1);
    draw_imm(r2);
    for (int i = 0; i < 64; i++) begin
      imem[i] = insn_nop;
    end
    // fill value depends on the full byte address
    for (int i = 0; i < 256; i++) begin
      dmem[i] = (i * 4) * 32'h9e37_79b9 + 32'h0000_1234;
    end
    // dependent alu chain
    imem[0]  = enc_i(r0, 0, 3'b000, 1, op_reg_imm);
    imem[1]  = enc_i(r1, 1, 3'b000, 2, op_reg_imm);
    imem[2]  = enc_r(7'd0, 2, 1, 3'b000, 3);
    imem[3]  = enc_r(7'd0, 1, 3, 3'b100, 4);
    imem[4]  = enc_s(12'h100, 4);
    imem[5]  = enc_r(funct7_alt, 2, 4, 3'b000, 5);
    imem[6]  = enc_s(12'h104, 5);
    // load followed by its use
    imem[7]  = enc_i(12'h100, 0, 3'b010, 6, op_load);
    imem[8]  = enc_i(r2, 6, 3'b000, 7, op_reg_imm);
    imem[9]  = enc_s(12'h108, 7);
    // taken beq skips one store
    imem[10] = enc_b(13'd8, 1, 1, 3'b000);
    imem[11] = enc_s(12'h10c, 3);
    imem[12] = enc_b(13'd8, 1, 1, 3'b001);
    // jal over a store, link goes to x8
    imem[13] = {1'b0, 10'd4, 1'b0, 8'd0, 5'd8, op_jal};
    imem[14] = enc_s(12'h110, 1);
    imem[15] = enc_s(12'h114, 8);
    imem[16] = enc_i(12'd5, 3, 3'b001, 9, op_reg_imm);
    imem[17] = enc_i({funct7_alt, 5'd3}, 4, 3'b101, 10, op_reg_imm);
    imem[18] = enc_s(12'h118, 9);
    imem[19] = enc_s(12'h11c, 10);
    imem[prog_len-1] = insn_ecall;
  end

  assign imem_data  = imem[imem_addr[7:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    if (dmem_we == 4'b1111) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
    end
  end

endmodule

// File: testbench/rv_pipe_tb.sv
`timescale 1ns/10ps

module rv_pipe_tb;
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  logic   clk;
  logic   rst;
  word_t  imem_addr;
  word_t  imem_data;
  word_t  dmem_addr;
  word_t  dmem_wdata;
  word_t  dmem_rdata;
  logic [3:0] dmem_we;
  logic   halt;
  trace_t trace;

  cycle_status_e exp_status [$];
  word_t         exp_pc [$];
  word_t         exp_insn [$];
  word_t         exp_st_addr [$];
  word_t         exp_st_data [$];
  int  value_errors;
  int  other_errors;
  int  after_reset;
  bit  started;
  bit  done;
  bit  last_retired;

  rv_pipe rv_pipe_i (
    .clk(clk), .rst(rst), .imem_data(imem_data), .dmem_rdata(dmem_rdata),
    .imem_addr(imem_addr), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
    .dmem_we(dmem_we), .halt(halt), .trace(trace)
  );

  rv_pipe_mem mem_i (
    .clk(clk), .imem_addr(imem_addr), .imem_data(imem_data), .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata), .dmem_we(dmem_we), .dmem_rdata(dmem_rdata)
  );

  always #50 clk = ~clk;

  function automatic word_t alu_op(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return word_t'($signed(a) < $signed(b));
      3'b011: return word_t'(a < b);
      3'b100: return a ^ b;
      3'b101: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  // architectural run of the program gives the expected trace and stores
  task automatic build_expected();
    word_t r [32];
    word_t dm [0:255];
    word_t pc;
    word_t insn;
    word_t nxt;
    word_t ii;
    word_t addr;
    opcode_t op;
    logic [4:0] rd;
    logic [4:0] s1;
    logic [4:0] s2;
    for (int i = 0; i < 32; i++) begin
      r[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
      dm[i] = mem_i.dmem[i];
    end
    pc = '0;
    for (int n = 0; n < 64; n++) begin
      insn = mem_i.imem[pc[7:2]];
      op = insn[6:0];
      rd = insn[11:7];
      s1 = insn[19:15];
      s2 = insn[24:20];
      ii = {{20{insn[31]}}, insn[31:20]};
      exp_status.push_back(cycle_no_stall);
      exp_pc.push_back(pc);
      exp_insn.push_back(insn);
      if (op == op_system) break;
      case (op)
        op_reg_imm: r[rd] = alu_op(insn[14:12], insn[14:12] == 3'b101 && insn[30], r[s1], ii);
        op_reg_reg: r[rd] = alu_op(insn[14:12], insn[30], r[s1], r[s2]);
        op_load: begin
          r[rd] = dm[(r[s1] + ii) >> 2];
          nxt = mem_i.imem[pc[7:2] + 1];
          // consumer right behind a load waits one cycle
          if (rd != 0 && ((nxt[6:0] inside {op_reg_imm, op_reg_reg, op_branch, op_load,
              op_store, op_jalr} && nxt[19:15] == rd) || (nxt[6:0] inside {op_reg_reg,
              op_branch, op_store} && nxt[24:20] == rd))) begin
            exp_status.push_back(cycle_load2use);
          end
        end
        op_store: begin
          addr = r[s1] + {{20{insn[31]}}, insn[31:25], insn[11:7]};
          exp_st_addr.push_back(addr);
          exp_st_data.push_back(r[s2]);
          dm[addr >> 2] = r[s2];
        end
        op_branch: begin
          if ((r[s1] == r[s2]) != insn[12]) begin
            exp_status.push_back(cycle_taken_branch);
            exp_status.push_back(cycle_taken_branch);
            pc = pc + {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0} - 4;
          end
        end
        op_jal: begin
          r[rd] = pc + 4;
          exp_status.push_back(cycle_taken_branch);
          exp_status.push_back(cycle_taken_branch);
          pc = pc + {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0} - 4;
        end
        default: begin
        end
      endcase
      r[0] = '0;
      pc = pc + 4;
    end
  endtask

  always @(negedge clk) begin
    if (rst || after_reset == 0) begin
      assert (trace.status == cycle_reset) else begin
        $display("MISMATCH %0t trace.status exp %0d got %0d", $time, cycle_reset,
                 trace.status);
        value_errors++;
      end
      assert (dmem_we == 4'b0000) else begin
        $display("MISMATCH %0t dmem_we exp %b got %b", $time, 4'b0000, dmem_we);
        value_errors++;
      end
      assert (!halt) else begin
        $display("MISMATCH %0t halt exp %b got %b", $time, 1'b0, halt);
        value_errors++;
      end
    end
    if (!rst && !done) begin
      after_reset++;
      last_retired = 0;
      if (!started && trace.status != cycle_reset) begin
        started = 1;
      end
      if (started) begin
        if (exp_status.size() == 0) begin
          $display("trace runs past the expected end at %0t", $time);
          other_errors++;
        end else begin
          assert (trace.status == exp_status[0]) else begin
            $display("MISMATCH %0t trace.status exp %0d got %0d", $time,
                     exp_status[0], trace.status);
            value_errors++;
          end
          if (exp_status.pop_front() == cycle_no_stall) begin
            assert (trace.pc == exp_pc[0]) else begin
              $display("MISMATCH %0t trace.pc exp %h got %h", $time, exp_pc[0], trace.pc);
              value_errors++;
            end
            assert (trace.insn == exp_insn[0]) else begin
              $display("MISMATCH %0t trace.insn exp %h got %h", $time, exp_insn[0],
                       trace.insn);
              value_errors++;
            end
            void'(exp_pc.pop_front());
            void'(exp_insn.pop_front());
            // the model ends on ecall, so the last retirement is the halt
            last_retired = exp_pc.size() == 0;
          end
        end
      end
      if (dmem_we == 4'b1111) begin
        if (exp_st_addr.size() == 0) begin
          $display("unexpected store at %0t to %h", $time, dmem_addr);
          other_errors++;
        end else begin
          assert (dmem_addr == exp_st_addr[0]) else begin
            $display("MISMATCH %0t dmem_addr exp %h got %h", $time, exp_st_addr[0],
                     dmem_addr);
            value_errors++;
          end
          assert (dmem_wdata == exp_st_data[0]) else begin
            $display("MISMATCH %0t dmem_wdata exp %h got %h", $time, exp_st_data[0],
                     dmem_wdata);
            value_errors++;
          end
          void'(exp_st_addr.pop_front());
          void'(exp_st_data.pop_front());
        end
      end
      assert (halt == last_retired) else begin
        $display("MISMATCH %0t halt exp %b got %b", $time, last_retired, halt);
        value_errors++;
      end
      if (halt || last_retired) begin
        assert (exp_st_addr.size() == 0 && exp_status.size() == 0) else begin
          $display("halt with %0d stores and %0d trace cycles still expected",
                   exp_st_addr.size(), exp_status.size());
          other_errors++;
        end
        done = 1;
      end
    end
  end

  // 20 cycles per retired instruction plus reset
  initial begin
    #2;
    #((20 * exp_pc.size() + 10) * 100);
    $display("timeout, halt never reached");
    $display("Test FAILED");
    $finish;
  end

  initial begin
    clk = 0;
    rst = 1;
    value_errors = 0;
    other_errors = 0;
    after_reset = 0;
    started = 0;
    done = 0;
    last_retired = 0;
    #1;
    build_expected();
    repeat (3) @(posedge clk);
    rst <= 0;
    wait (done);
    $display("errors: %0d mismatches, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
